// File: pool_top.f
hw/pool_pkg.sv
hw/pool_step_if.sv
hw/pool_ctrl_fsm.sv
hw/pool_window_counter.sv
hw/pool_row_max.sv
hw/pool_pack_buffer.sv
hw/pool_top.sv
testbench/pool_tb.sv

// File: Bender.yml
package:
  name: pool_top

sources:
  - hw/pool_pkg.sv
  - hw/pool_step_if.sv
  - hw/pool_ctrl_fsm.sv
  - hw/pool_window_counter.sv
  - hw/pool_row_max.sv
  - hw/pool_pack_buffer.sv
  - hw/pool_top.sv
  - target: simulation
    files:
      - testbench/pool_tb.sv

// File: testbench/pool_testdata.hex
// one 64-bit hex value per line, byte 0 (low) = column 0 / earliest pooled value
// entries 0-7 picture rows, 8-11 expected words run 1, 12-15 expected words run 2
// picture rows 0..7
5655019044037f12
5556a08f43450080
70605040302010ff
0807060504030201
0000000000000000
fe00c4c300000100
a1a09f9e9d9c9b9a
44332211b2b3b0b1
// expected words, result base 0x00000
0000000056a04580
000000007050_30ff
00000000fec40001
00000000a19fb3b1
// expected words, result base 0x00800
0000000056a04580
00000000705030ff
00000000fec40001
00000000a19fb3b1

// File: testbench/pool_tb.sv
/*
 * Testbench for the max-pooling unit, 8x8 picture, 2x2 window, stride 2.
 * Memory model answers reads and writes after 0..3 LFSR-chosen cycles.
 * Picture rows and expected words come from testbench/pool_testdata.hex.
 */

`timescale 1ns/100ps
`default_nettype none

module pool_tb;

	localparam int READS  = 32;                             // 16 windows x 2 lines
	localparam int WRITES = 4;                              // 16 pooled bytes
	localparam int LIMIT  = (READS + WRITES) * 8 * 2 + 200; // cycles, incl reset and margin
	localparam pool_pkg::addr_t PIC_BASE = 19'h00400;       // picture start

	logic               clk;
	logic               rst_n;
	pool_pkg::addr_t    pool_addr_x, pool_addr_z;
	logic               go, busy, done;
	logic               rd_req, rd_valid;
	pool_pkg::addr_t    rd_addr;
	pool_pkg::wr_size_t rd_size;
	pool_pkg::rd_line_t rd_data;
	logic               wr_req, wr_ack;
	pool_pkg::addr_t    wr_addr;
	pool_pkg::wr_word_t wr_data;
	pool_pkg::wr_size_t wr_size;

	logic [63:0]        tdata [0:15];       // rows, then expected words
	logic [31:0]        lfsr;
	int                 reads, done_count, accepted, unstable, size_errs, raddr_errs;
	int                 tests_ok, tests_bad;
	string              addr_test;          // name of the running address test
	pool_pkg::addr_t    got_addr [$];       // completed writes, in order
	pool_pkg::wr_word_t got_data [$];
	pool_pkg::wr_size_t got_size [$];

	pool_top #(.PIC_ROWS(8), .PIC_COLS(8), .WIN(2), .STRIDE(2)) dut_i (.clk, .rst_n,
		.pool_addr_x, .pool_addr_z, .go, .busy, .done, .rd_req, .rd_addr, .rd_size, .rd_valid,
		.rd_data, .wr_req, .wr_addr, .wr_data, .wr_size, .wr_ack);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;                       // 100 ns period
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic int rand_bits(input int n);
		int v;
		int k;
		v = 0;
		for (k = 0; k < n; k++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	task automatic show_mismatch(input string test, input logic [63:0] exp, input logic [63:0] act);
		$display("[ERROR] %s expected %h actual %h", test, exp, act);
	endtask

	task automatic end_test(input string test, input int errs);
		if (errs == 0)
		begin
			tests_ok++;
			$display("test %-20s ok", test);
		end
		else
		begin
			tests_bad++;
			$display("test %-20s failed with %0d errors", test, errs);
		end
	endtask

	// ========================================
	// memory model
	// ========================================
	initial
	begin : read_model
		int              delay;
		pool_pkg::addr_t off;
		pool_pkg::addr_t exp_a;
		forever
		begin
			@(negedge clk);
			if (rd_req)
			begin
				// read n is line n%2 of window n/2, four windows per row
				exp_a = PIC_BASE + pool_pkg::addr_t'(((reads / 8) * 2 + reads % 2) * 8
					+ ((reads / 2) % 4) * 2);
				if (rd_addr !== exp_a)
				begin
					raddr_errs++;
					show_mismatch(addr_test, exp_a, rd_addr);
				end
				off   = rd_addr - PIC_BASE;              // byte offset into picture
				delay = rand_bits(2);
				if (rd_size !== 3'd2)
				begin
					size_errs++;
					show_mismatch(addr_test, 3'd2, rd_size);
				end
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#10;
				rd_valid = 1'b1;
				rd_data  = tdata[off / 8] >> (8 * (off % 8));   // lane 0 = start byte
				reads++;
				@(posedge clk);
				#10;
				rd_valid = 1'b0;
			end
		end
	end

	initial
	begin : write_model
		int                 delay;
		int                 k;
		pool_pkg::addr_t    a;
		pool_pkg::wr_word_t d;
		pool_pkg::wr_size_t s;
		forever
		begin
			@(negedge clk);
			if (wr_req)
			begin
				a     = wr_addr;                         // snapshot of the request
				d     = wr_data;
				s     = wr_size;
				delay = rand_bits(2);
				for (k = 0; k <= delay; k++)
				begin
					if (k == delay)
					begin
						@(posedge clk);
						#10;
						wr_ack = 1'b1;                   // taken on the next edge
					end
					@(negedge clk);
					if (!wr_req || wr_addr !== a || wr_data !== d || wr_size !== s)
					begin
						unstable++;
						$display("write request changed while waiting for ack at %0t", $time);
					end
				end
				@(posedge clk);
				#10;
				wr_ack = 1'b0;
				got_addr.push_back(a);
				got_data.push_back(d);
				got_size.push_back(s);
			end
		end
	end

	always @(negedge clk)
		if (done)
			done_count++;

	initial
	begin : watchdog
		repeat (LIMIT) @(posedge clk);
		$display("timeout, the runs did not finish within %0d cycles", LIMIT);
		$display("** FAIL **");
		$finish;
	end

	// ========================================
	// one frame, go to done, then checks
	// ========================================
	task automatic run_frame(input string tag, input pool_pkg::addr_t z_base, input int exp_idx,
		input bit poke_go);
		int    errs;
		int    errs_bd;
		int    cycles;
		int    i;
		bit    ended;
		string t_words, t_addr, t_bd, t_bp;
		t_words = $sformatf("%s_words", tag);
		t_addr  = $sformatf("%s_addr_size", tag);
		t_bd    = $sformatf("%s_busy_done", tag);
		t_bp    = $sformatf("%s_backpressure", tag);
		errs_bd = 0;
		cycles  = 0;
		ended   = 1'b0;
		unstable   = 0;
		reads      = 0;
		size_errs  = 0;
		raddr_errs = 0;
		addr_test  = t_addr;
		got_addr.delete();
		got_data.delete();
		got_size.delete();
		@(posedge clk);
		#10;
		pool_addr_z = z_base;
		go          = 1'b1;
		accepted++;
		while (!ended)
		begin
			@(posedge clk);
			#10;
			go = poke_go && (cycles == 4);              // extra go while busy
			@(negedge clk);
			if (done)
				ended = 1'b1;
			else if (!busy)
			begin
				errs_bd++;
				$display("%s: busy low before done", t_bd);
			end
			cycles++;
		end
		if (busy)
		begin
			errs_bd++;
			$display("%s: busy high in the done cycle", t_bd);
		end
		@(negedge clk);
		if (done || busy)
		begin
			errs_bd++;
			$display("%s: done or busy still high one cycle after done", t_bd);
		end
		if (done_count != accepted)
		begin
			errs_bd++;
			show_mismatch(t_bd, accepted, done_count);
		end

		errs = 0;
		for (i = 0; i < WRITES; i++)
		begin
			if (i >= got_data.size())
			begin
				errs++;
				$display("%s: write %0d never happened", t_words, i);
			end
			else if (got_data[i] !== tdata[exp_idx + i][31:0])
			begin
				errs++;
				show_mismatch(t_words, tdata[exp_idx + i][31:0], got_data[i]);
			end
		end
		end_test(t_words, errs);

		errs = size_errs + raddr_errs;
		for (i = 0; i < got_addr.size(); i++)
		begin
			if (got_addr[i] !== z_base + pool_pkg::addr_t'(4 * i))
			begin
				errs++;
				show_mismatch(t_addr, z_base + pool_pkg::addr_t'(4 * i), got_addr[i]);
			end
			if (got_size[i] !== 3'd4)
			begin
				errs++;
				show_mismatch(t_addr, 3'd4, got_size[i]);
			end
		end
		end_test(t_addr, errs);
		end_test(t_bd, errs_bd);

		errs = unstable;
		if (got_data.size() != WRITES)
		begin
			errs++;
			show_mismatch(t_bp, WRITES, got_data.size());
		end
		if (reads != READS)
		begin
			errs++;
			show_mismatch(t_bp, READS, reads);
		end
		end_test(t_bp, errs);
	endtask

	initial
	begin : main
		int errs;
		lfsr        = 32'ha3b1_458a;
		rst_n       = 1'b0;
		go          = 1'b0;
		pool_addr_x = PIC_BASE;
		pool_addr_z = '0;
		rd_valid    = 1'b0;
		rd_data     = '0;
		wr_ack      = 1'b0;
		reads       = 0;
		done_count  = 0;
		accepted    = 0;
		unstable    = 0;
		size_errs   = 0;
		raddr_errs  = 0;
		addr_test   = "reads";
		tests_ok    = 0;
		tests_bad   = 0;
		$readmemh("testbench/pool_testdata.hex", tdata);
		repeat (10) @(posedge clk);                    // reset for 10 cycles
		#10;
		rst_n = 1'b1;
		@(negedge clk);
		errs = 0;
		if (busy !== 1'b0 || done !== 1'b0 || rd_req !== 1'b0 || wr_req !== 1'b0)
		begin
			errs++;
			show_mismatch("reset", 4'b0000, {busy, done, rd_req, wr_req});
		end
		end_test("reset", errs);
		run_frame("run1", 19'h00000, 8, 1'b0);
		run_frame("run2", 19'h00800, 12, 1'b1);      // moved result base
		$display("tests passed %0d, failed %0d", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/pool_top.sv
/*
 * Max-pooling unit, square WIN x WIN window moving by STRIDE in both directions.
 * Picture and window sizes are fixed at elaboration. WIN must not exceed 8.
 * pool_addr_x and pool_addr_z must stay steady from go until done.
 */

`timescale 1ns/100ps
`default_nettype none

module pool_top #(
	parameter int PIC_ROWS = 8,
	parameter int PIC_COLS = 8,
	parameter int WIN      = 2,
	parameter int STRIDE   = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  pool_pkg::addr_t    pool_addr_x,
	input  pool_pkg::addr_t    pool_addr_z,
	input  logic               go,
	output logic               busy,
	output logic               done,
	output logic               rd_req,
	output pool_pkg::addr_t    rd_addr,
	output pool_pkg::wr_size_t rd_size,
	input  logic               rd_valid,
	input  pool_pkg::rd_line_t rd_data,
	output logic               wr_req,
	output pool_pkg::addr_t    wr_addr,
	output pool_pkg::wr_word_t wr_data,
	output pool_pkg::wr_size_t wr_size,
	input  logic               wr_ack
);

	pool_step_if    step_if ();
	pool_pkg::pix_t pooled;
	logic           word_full, word_pending;

	assign rd_size = pool_pkg::wr_size_t'(WIN);   // one window row per read

	pool_ctrl_fsm ctrl_i (.clk, .rst_n, .go, .busy, .done, .rd_req, .rd_valid, .wr_req, .wr_ack,
		.word_full, .word_pending, .step(step_if.fsm));
	pool_window_counter #(.PIC_ROWS(PIC_ROWS), .PIC_COLS(PIC_COLS), .WIN(WIN), .STRIDE(STRIDE))
		counter_i (.clk, .rst_n, .pool_addr_x, .rd_addr, .step(step_if.counter));
	pool_row_max #(.WIN(WIN)) row_max_i (.clk, .rst_n, .rd_valid, .rd_data, .pooled,
		.step(step_if.data));
	pool_pack_buffer pack_i (.clk, .rst_n, .pool_addr_z, .pooled, .wr_addr, .wr_data, .wr_size,
		.word_full, .word_pending, .step(step_if.data));

endmodule

`default_nettype wire

// File: hw/pool_pack_buffer.sv
/*
 * Packs pooled bytes into a write word, low byte first, and tracks the write address.
 * pool_addr_z is sampled on go. Unused bytes of a short last word read as zero.
 * wr_addr, wr_data and wr_size hold steady until the word is acknowledged.
 */

`timescale 1ns/100ps
`default_nettype none

module pool_pack_buffer (
	input  logic               clk,
	input  logic               rst_n,
	input  pool_pkg::addr_t    pool_addr_z,   // result base
	input  pool_pkg::pix_t     pooled,
	output pool_pkg::addr_t    wr_addr,
	output pool_pkg::wr_word_t wr_data,
	output pool_pkg::wr_size_t wr_size,
	output logic               word_full,
	output logic               word_pending,
	pool_step_if.data          step
);

	pool_pkg::wr_size_t fill;    // bytes in word
	logic               add;     // window finished, byte enters

	assign add     = step.line_step && step.line_last;
	assign wr_size = fill;

	// both flags count the byte entering this cycle
	assign word_full    = (fill == pool_pkg::WR_BYTES) ||
		(add && (fill == pool_pkg::WR_BYTES - 1));
	assign word_pending = (fill != '0) || add;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fill    <= '0;
			wr_data <= '0;
			wr_addr <= '0;
		end
		else if (step.clear)
		begin
			fill    <= '0;
			wr_data <= '0;
			wr_addr <= pool_addr_z;
		end
		else if (step.word_sent)
		begin
			fill    <= '0;
			wr_data <= '0;                       // zero fill for next word
			wr_addr <= wr_addr + wr_size;
		end
		else if (add)
		begin
			wr_data[fill*pool_pkg::PIX_W +: pool_pkg::PIX_W] <= pooled;
			fill <= fill + 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		add |-> (fill < pool_pkg::WR_BYTES));

endmodule

`default_nettype wire

// File: hw/pool_row_max.sv
/*
 * Holds the fetched line and the running maximum of the current window.
 * Only lanes 0..WIN-1 take part, the upper lanes are ignored.
 * pooled is meaningful in the REDUCE cycle only.
 */

`timescale 1ns/100ps
`default_nettype none

module pool_row_max #(
	parameter int WIN = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rd_valid,
	input  pool_pkg::rd_line_t rd_data,
	output pool_pkg::pix_t     pooled,
	pool_step_if.data          step
);

	pool_pkg::rd_line_t line_q;      // captured read line
	pool_pkg::pix_t     run_q;       // max over earlier lines of window
	pool_pkg::pix_t     lane_max;    // max within current line
	pool_pkg::pix_t     prev_max;

	always_ff @(posedge clk)
	begin
		if (rd_valid)
			line_q <= rd_data;
	end

	always_comb
	begin
		lane_max = '0;
		for (int i = 0; i < WIN; i++)
			if (line_q[i*pool_pkg::PIX_W +: pool_pkg::PIX_W] > lane_max)
				lane_max = line_q[i*pool_pkg::PIX_W +: pool_pkg::PIX_W];
	end

	assign prev_max = step.first_line ? '0 : run_q;     // restart per window
	assign pooled   = (prev_max > lane_max) ? prev_max : lane_max;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			run_q <= '0;
		else if (step.line_step)
			run_q <= pooled;
	end

endmodule

`default_nettype wire

// File: hw/pool_window_counter.sv
/*
 * Line, window column and window row counters plus the registered read address.
 * pool_addr_x must stay steady while busy. Pictures are row-major, PIC_COLS bytes per row.
 * Windows that would run past the picture edge are not visited.
 */

`timescale 1ns/100ps
`default_nettype none

module pool_window_counter #(
	parameter int PIC_ROWS = 8,
	parameter int PIC_COLS = 8,
	parameter int WIN      = 2,
	parameter int STRIDE   = 2
) (
	input  logic            clk,
	input  logic            rst_n,
	input  pool_pkg::addr_t pool_addr_x,   // picture base
	output pool_pkg::addr_t rd_addr,
	pool_step_if.counter    step
);

	localparam int COL_LAST = (PIC_COLS - WIN) / STRIDE;   // last window column index
	localparam int ROW_LAST = (PIC_ROWS - WIN) / STRIDE;   // last window row index
	localparam int LINE_W   = $clog2(WIN + 1);
	localparam int COL_W    = $clog2(COL_LAST + 2);
	localparam int ROW_W    = $clog2(ROW_LAST + 2);

	logic [LINE_W-1:0] line_q, line_d;     // line within window
	logic [COL_W-1:0]  col_q, col_d;       // window column
	logic [ROW_W-1:0]  row_q, row_d;       // window row
	logic              col_last;

	assign step.first_line = (line_q == '0);
	assign step.line_last  = (line_q == LINE_W'(WIN - 1));
	assign col_last        = (col_q == COL_W'(COL_LAST));
	assign step.frame_last = col_last && (row_q == ROW_W'(ROW_LAST));

	// next position, wraps to zero after the last window
	always_comb
	begin
		line_d = line_q + 1'b1;
		col_d  = col_q;
		row_d  = row_q;
		if (step.line_last)
		begin
			line_d = '0;
			col_d  = col_last ? '0 : col_q + 1'b1;
			if (col_last)
				row_d = step.frame_last ? '0 : row_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			line_q  <= '0;
			col_q   <= '0;
			row_q   <= '0;
			rd_addr <= '0;
		end
		else if (step.clear)
		begin
			line_q  <= '0;
			col_q   <= '0;
			row_q   <= '0;
			rd_addr <= pool_addr_x;              // window 0, line 0
		end
		else if (step.line_step)
		begin
			line_q  <= line_d;
			col_q   <= col_d;
			row_q   <= row_d;
			// base + (row*S + line)*cols + col*S
			rd_addr <= pool_addr_x + pool_pkg::addr_t'((row_d * STRIDE + line_d) * PIC_COLS
				+ col_d * STRIDE);
		end
	end

	a_col_range: assert property (@(posedge clk) disable iff (!rst_n) col_q <= COL_W'(COL_LAST));

endmodule

`default_nettype wire

// File: hw/pool_ctrl_fsm.sv
/*
 * Sequences read, reduce and write for every window of the frame.
 * rd_req and wr_req are held until rd_valid / wr_ack. go is ignored unless idle.
 * busy and done decode straight from the state register.
 */

`timescale 1ns/100ps
`default_nettype none

module pool_ctrl_fsm (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            go,
	output logic            busy,
	output logic            done,
	output logic            rd_req,
	input  logic            rd_valid,
	output logic            wr_req,
	input  logic            wr_ack,
	input  logic            word_full,      // word complete after current byte
	input  logic            word_pending,   // word holds unwritten bytes
	pool_step_if.fsm        step
);

	pool_pkg::pool_state_t state, state_d;
	logic                  last_word;       // final window is in the buffer

	// ======================================
	// state register
	// ======================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= pool_pkg::IDLE;
			last_word <= 1'b0;
		end
		else
		begin
			state <= state_d;
			if (step.clear)
				last_word <= 1'b0;
			else if (step.line_step && step.line_last && step.frame_last)
				last_word <= 1'b1;              // flush pending, then done
		end
	end

	always_comb
	begin
		state_d = state;
		case (state)
			pool_pkg::IDLE:   if (go) state_d = pool_pkg::READ;
			pool_pkg::READ:   if (rd_valid) state_d = pool_pkg::REDUCE;
			pool_pkg::REDUCE:
			begin
				state_d = pool_pkg::READ;        // default, next line
				if (step.line_last && (word_full || (step.frame_last && word_pending)))
					state_d = pool_pkg::WRITE;
			end
			pool_pkg::WRITE:  if (wr_ack) state_d = last_word ? pool_pkg::DONE : pool_pkg::READ;
			default:          state_d = pool_pkg::IDLE;   // DONE lasts one cycle
		endcase
	end

	// ======================================
	// strobes and status
	// ======================================
	assign step.clear     = (state == pool_pkg::IDLE) && go;
	assign step.line_step = (state == pool_pkg::REDUCE);
	assign step.word_sent = (state == pool_pkg::WRITE) && wr_ack;
	assign rd_req         = (state == pool_pkg::READ);
	assign wr_req         = (state == pool_pkg::WRITE);
	assign done           = (state == pool_pkg::DONE);
	assign busy           = (state != pool_pkg::IDLE) && !done;

	a_one_req: assert property (@(posedge clk) disable iff (!rst_n) !(rd_req && wr_req));
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);
	// everything reached memory before done
	a_flushed: assert property (@(posedge clk) disable iff (!rst_n) done |-> !word_pending);

endmodule

`default_nettype wire

// File: hw/pool_step_if.sv
/*
 * Step strobes from the FSM and window flags from the counter.
 * All signals are synchronous to the unit clock, and the strobes are one cycle wide.
 */

`timescale 1ns/100ps
`default_nettype none

interface pool_step_if;

	logic clear;          // go accepted, reload everything
	logic line_step;      // REDUCE cycle, one line consumed
	logic word_sent;      // write acknowledged
	logic line_last;      // current line ends its window
	logic frame_last;     // current window ends the frame
	logic first_line;     // current line opens a window

	modport fsm (output clear, line_step, word_sent,
		input line_last, frame_last);

	modport counter (input clear, line_step,
		output line_last, frame_last, first_line);

	modport data (input clear, line_step, word_sent,
		input line_last, frame_last, first_line);

endinterface

`default_nettype wire

// File: hw/pool_pkg.sv
/*
 * Shared widths, vector types and FSM encoding of the max-pooling unit.
 * Pixels are 8-bit unsigned. One read returns LANES bytes, and WIN may not exceed it.
 * A write word carries WR_BYTES pooled bytes, low byte first.
 */

`default_nettype none

package pool_pkg;

	// ======================================
	// widths
	// ======================================
	localparam int ADDR_W   = 19;                      // byte address
	localparam int PIX_W    = 8;                       // one pixel
	localparam int LANES    = 8;                       // bytes per read, upper bound of WIN
	localparam int WR_BYTES = 4;                       // pooled bytes per write word

	// ======================================
	// vector types
	// ======================================
	typedef logic [ADDR_W-1:0]         addr_t;         // byte address
	typedef logic [PIX_W-1:0]          pix_t;          // pixel or pooled value
	typedef logic [LANES*PIX_W-1:0]    rd_line_t;      // lane 0 = byte at start addr
	typedef logic [WR_BYTES*PIX_W-1:0] wr_word_t;      // byte 0 = earliest pooled value
	typedef logic [2:0]                wr_size_t;      // byte count, 0..WR_BYTES

	typedef enum logic [2:0]
	{
		IDLE   = 3'd0,
		READ   = 3'd1,
		REDUCE = 3'd2,
		WRITE  = 3'd3,
		DONE   = 3'd4
	} pool_state_t;

endpackage

`default_nettype wire
